// ==== atmPkg.sv ====
package atmPkg;

    localparam int MoneyWidth     = 12;
    localparam int SwitchWidth    = 16;
    localparam int BcdDigits      = 4;
    localparam int ScanDigits     = 6;
    localparam int Pin            = 31;
    localparam int InitialBalance = 2500;
    localparam int MaxBalance     = 4095;
    localparam int ScanDivide     = 10000;   // clocks per lit digit
    localparam int BcdSteps       = MoneyWidth;

    typedef logic [MoneyWidth-1:0]  money;
    typedef logic [SwitchWidth-1:0] switchWord;

    typedef struct packed {
        logic cancel;
        logic withdraw;
        logic deposit;
        logic confirm;
    } atmButtons;

    typedef enum logic [3:0] {
        Glyph0, Glyph1, Glyph2, Glyph3, Glyph4,
        Glyph5, Glyph6, Glyph7, Glyph8, Glyph9,
        Dash, LetterR, LetterO, LetterE, Blank
    } glyph;

    typedef struct packed {
        logic [3:0] thousands;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } bcdWord;

    typedef struct packed {
        glyph slot5;   // leftmost
        glyph slot4;
        glyph slot3;
        glyph slot2;
        glyph slot1;
        glyph slot0;
    } displayFrame;

    // active low, dp on bit 7, then gfedcba
    typedef logic [7:0] segPattern;

    typedef enum logic [3:0] {
        Idle, Menu, Withdraw, Deposit, WithdrawDone, DepositDone,
        ErrPin, ErrFunds, ErrOverflow
    } atmState;

    localparam segPattern glyphSegments [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
        8'h92, 8'h82, 8'hF8, 8'h80, 8'h98,
        8'hBF,   // dash
        8'hAF,   // r
        8'hA3,   // o
        8'h86,   // E
        8'hFF,   // blank
        8'hFF
    };

endpackage

// ==== atmController.sv ====
`timescale 1ns/1ps

module atmController (
    input  logic                clk,
    input  logic                arstN,
    input  atmPkg::switchWord   switches,
    input  atmPkg::atmButtons   buttons,
    input  atmPkg::bcdWord      bcdDigits,
    output atmPkg::money        bcdValue,
    output atmPkg::displayFrame frame
);

    atmPkg::atmState state;
    atmPkg::atmState stateNext;
    atmPkg::money    balance;
    atmPkg::money    balanceNext;
    atmPkg::money    amount;
    atmPkg::glyph    errDigit;
    logic [atmPkg::MoneyWidth:0] depositSum;   // one spare bit for overflow
    logic            switchesClear;

    assign amount        = switches[atmPkg::MoneyWidth-1:0];
    assign depositSum    = {1'b0, balance} + {1'b0, amount};
    assign switchesClear = (switches == '0);

    always_comb
    begin
        stateNext   = state;
        balanceNext = balance;
        if (buttons.cancel)
        begin
            stateNext   = atmPkg::Idle;
            balanceNext = atmPkg::money'(atmPkg::InitialBalance);
        end
        else
        begin
            case (state)
                atmPkg::Idle:
                begin
                    if (buttons.confirm)
                    begin
                        stateNext = (switches == atmPkg::Pin) ? atmPkg::Menu : atmPkg::ErrPin;
                    end
                end
                atmPkg::Menu:
                begin
                    if (switchesClear && buttons.withdraw)
                    begin
                        stateNext = atmPkg::Withdraw;
                    end
                    else if (switchesClear && buttons.deposit)
                    begin
                        stateNext = atmPkg::Deposit;
                    end
                end
                atmPkg::Withdraw:
                begin
                    if (buttons.confirm && (amount > balance))
                    begin
                        stateNext = atmPkg::ErrFunds;
                    end
                    else if (buttons.confirm)
                    begin
                        stateNext   = atmPkg::WithdrawDone;
                        balanceNext = balance - amount;
                    end
                end
                atmPkg::Deposit:
                begin
                    if (buttons.confirm && (depositSum > atmPkg::MaxBalance))
                    begin
                        stateNext = atmPkg::ErrOverflow;
                    end
                    else if (buttons.confirm)
                    begin
                        stateNext   = atmPkg::DepositDone;
                        balanceNext = depositSum[atmPkg::MoneyWidth-1:0];
                    end
                end
                atmPkg::WithdrawDone, atmPkg::DepositDone,
                atmPkg::ErrFunds, atmPkg::ErrOverflow:
                begin
                    if (buttons.confirm && switchesClear)
                    begin
                        stateNext = atmPkg::Menu;
                    end
                end
                atmPkg::ErrPin:
                begin
                    if (buttons.confirm)
                    begin
                        stateNext = atmPkg::Idle;
                    end
                end
                default:
                begin
                    stateNext = atmPkg::Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state   <= atmPkg::Idle;
            balance <= atmPkg::money'(atmPkg::InitialBalance);
        end
        else
        begin
            state   <= stateNext;
            balance <= balanceNext;
        end
    end

    // typed amount is shown while entering it
    assign bcdValue = (state == atmPkg::Withdraw || state == atmPkg::Deposit) ? amount : balance;

    always_comb
    begin
        case (state)
            atmPkg::ErrFunds:    errDigit = atmPkg::Glyph2;
            atmPkg::ErrOverflow: errDigit = atmPkg::Glyph3;
            default:             errDigit = atmPkg::Glyph1;
        endcase
        case (state)
            atmPkg::Idle:
                frame = '{atmPkg::Blank, atmPkg::Blank, atmPkg::Dash,
                          atmPkg::Dash, atmPkg::Dash, atmPkg::Dash};
            atmPkg::ErrPin, atmPkg::ErrFunds, atmPkg::ErrOverflow:
                frame = '{atmPkg::LetterE, atmPkg::LetterR, atmPkg::LetterR,
                          atmPkg::LetterO, atmPkg::LetterR, errDigit};
            default:
                frame = '{atmPkg::Blank, atmPkg::Blank,
                          atmPkg::glyph'(bcdDigits.thousands), atmPkg::glyph'(bcdDigits.hundreds),
                          atmPkg::glyph'(bcdDigits.tens), atmPkg::glyph'(bcdDigits.ones)};
        endcase
    end

    stateLegal: assert property (@(posedge clk) disable iff (!arstN)
        state inside {atmPkg::Idle, atmPkg::Menu, atmPkg::Withdraw, atmPkg::Deposit,
                      atmPkg::WithdrawDone, atmPkg::DepositDone, atmPkg::ErrPin,
                      atmPkg::ErrFunds, atmPkg::ErrOverflow});

    // an accepted deposit must not wrap past MaxBalance
    balanceBound: assert property (@(posedge clk) disable iff (!arstN)
        ($past(state) == atmPkg::Deposit && state == atmPkg::DepositDone)
            |-> balance >= $past(balance));

endmodule

// ==== binToBcd.sv ====
`timescale 1ns/1ps

module binToBcd (
    input  logic           clk,
    input  logic           arstN,
    input  atmPkg::money   bcdValue,
    output atmPkg::bcdWord bcdDigits,
    output logic           bcdBusy
);

    logic [4*atmPkg::BcdDigits+atmPkg::MoneyWidth-1:0] work;
    logic [4*atmPkg::BcdDigits+atmPkg::MoneyWidth-1:0] workNext;
    logic [$clog2(atmPkg::BcdSteps+1)-1:0] stepCount;
    atmPkg::money lastValue;

    // one shift-and-add-3 step
    always_comb
    begin
        workNext = work;
        for (int d = 0; d < atmPkg::BcdDigits; d++)
        begin
            if (workNext[atmPkg::MoneyWidth+4*d +: 4] >= 4'd5)
            begin
                workNext[atmPkg::MoneyWidth+4*d +: 4] = workNext[atmPkg::MoneyWidth+4*d +: 4] + 4'd3;
            end
        end
        workNext = workNext << 1;
    end

    always_ff @(posedge clk)
    begin
        if (!bcdBusy)
        begin
            work <= {{(4*atmPkg::BcdDigits){1'b0}}, bcdValue};   // load while idle
        end
        else
        begin
            work <= workNext;
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            bcdBusy   <= 1'b0;
            stepCount <= '0;
            lastValue <= '0;
            bcdDigits <= '0;   // matches lastValue of zero
        end
        else if (!bcdBusy)
        begin
            if (bcdValue != lastValue)
            begin
                bcdBusy   <= 1'b1;
                lastValue <= bcdValue;
                stepCount <= '0;
            end
        end
        else
        begin
            stepCount <= stepCount + 1'b1;
            if (stepCount == atmPkg::BcdSteps - 1)
            begin
                bcdBusy   <= 1'b0;
                bcdDigits <= atmPkg::bcdWord'(workNext[$bits(work)-1 -: 4*atmPkg::BcdDigits]);
            end
        end
    end

    digitsDecimal: assert property (@(posedge clk) disable iff (!arstN)
        $fell(bcdBusy) |-> (bcdDigits.thousands <= 4'd9) && (bcdDigits.hundreds <= 4'd9) &&
                           (bcdDigits.tens <= 4'd9) && (bcdDigits.ones <= 4'd9));

endmodule

// ==== displayScan.sv ====
`timescale 1ns/1ps

module displayScan #(
    parameter int scanDivide = atmPkg::ScanDivide
) (
    input  logic                clk,
    input  logic                arstN,
    input  atmPkg::displayFrame frame,
    output atmPkg::segPattern   seg,
    output logic [7:0]          digitEn
);

    logic [$clog2(scanDivide+1)-1:0]       divCount;
    logic [$clog2(atmPkg::ScanDigits)-1:0] slot;
    logic                                  slotAdvance;
    atmPkg::glyph                          slotGlyph;

    assign slotAdvance = (divCount == scanDivide - 1);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            divCount <= '0;
            slot     <= '0;
        end
        else if (slotAdvance)
        begin
            divCount <= '0;
            slot     <= (slot == atmPkg::ScanDigits - 1) ? '0 : slot + 1'b1;
        end
        else
        begin
            divCount <= divCount + 1'b1;
        end
    end

    always_comb
    begin
        case (slot)
            3'd0:    slotGlyph = frame.slot0;
            3'd1:    slotGlyph = frame.slot1;
            3'd2:    slotGlyph = frame.slot2;
            3'd3:    slotGlyph = frame.slot3;
            3'd4:    slotGlyph = frame.slot4;
            3'd5:    slotGlyph = frame.slot5;
            default: slotGlyph = atmPkg::Blank;
        endcase
    end

    // segments and enable leave together
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            seg     <= '1;
            digitEn <= '1;
        end
        else
        begin
            seg     <= atmPkg::glyphSegments[slotGlyph];
            digitEn <= ~(8'b1 << slot);
        end
    end

    oneDigitLit: assert property (@(posedge clk) disable iff (!arstN)
        $countones(~digitEn) <= 1);

endmodule

// ==== atmTop.sv ====
`timescale 1ns/1ps

module atmTop #(
    parameter int scanDivide = atmPkg::ScanDivide
) (
    input  logic              clk,
    input  logic              arstN,
    input  atmPkg::switchWord switches,
    input  atmPkg::atmButtons buttons,
    output atmPkg::segPattern seg,
    output logic [7:0]        digitEn
);

    atmPkg::money        bcdValue;
    atmPkg::bcdWord      bcdDigits;
    atmPkg::displayFrame frame;

    atmController u_controller (
        .clk       (clk),
        .arstN     (arstN),
        .switches  (switches),
        .buttons   (buttons),
        .bcdDigits (bcdDigits),
        .bcdValue  (bcdValue),
        .frame     (frame)
    );

    binToBcd u_binToBcd (
        .clk       (clk),
        .arstN     (arstN),
        .bcdValue  (bcdValue),
        .bcdDigits (bcdDigits),
        .bcdBusy   ()
    );

    displayScan #(
        .scanDivide (scanDivide)
    ) u_displayScan (
        .clk     (clk),
        .arstN   (arstN),
        .frame   (frame),
        .seg     (seg),
        .digitEn (digitEn)
    );

endmodule

// ==== atmTbChecks.svh ====
`ifndef ATM_TB_CHECKS_SVH
`define ATM_TB_CHECKS_SVH

// one full scan, sampled on the falling edge
task automatic readFrame();
    logic [atmPkg::ScanDigits-1:0] seen;
    seen = '0;
    repeat (FrameCycles)
    begin
        @(negedge clk);
        if (digitEn[7:6] !== 2'b11)
        begin
            $display("Fail digitEn: got 0x%02h, bits 7 and 6 must stay high", digitEn);
            errorCount++;
        end
        for (int i = 0; i < atmPkg::ScanDigits; i++)
        begin
            if (digitEn[i] === 1'b0)
            begin
                recordedSeg[i] = seg;
                seen[i]        = 1'b1;
            end
        end
    end
    for (int i = 0; i < atmPkg::ScanDigits; i++)
    begin
        if (!seen[i])
        begin
            $display("Error: slot %0d was never enabled during a full scan", i);
            errorCount++;
        end
    end
endtask

task automatic checkSeg(input string slotName, input atmPkg::segPattern got,
                        input atmPkg::segPattern expected);
    if (got !== expected)
    begin
        $display("Fail seg %s: got 0x%02h, expected 0x%02h", slotName, got, expected);
        errorCount++;
    end
endtask

task automatic checkFrame(input atmPkg::displayFrame expected);
    atmPkg::glyph slotGlyph;
    for (int i = 0; i < atmPkg::ScanDigits; i++)
    begin
        slotGlyph = atmPkg::glyph'(expected[4*i +: 4]);   // slot0 in the low nibble
        checkSeg($sformatf("slot%0d", i), recordedSeg[i], atmPkg::glyphSegments[slotGlyph]);
    end
endtask

`endif

// ==== atmTb.sv ====
`timescale 1ns/1ps

module atmTb;

    localparam int ScanDiv     = 8;
    localparam int FrameCycles = atmPkg::ScanDigits * ScanDiv;
    localparam int FrameReads  = 16;
    localparam int CycleLimit  = FrameReads * 6 * ScanDiv * 3 + 500;

    localparam atmPkg::atmButtons ConfirmKey  = 4'b0001;
    localparam atmPkg::atmButtons DepositKey  = 4'b0010;
    localparam atmPkg::atmButtons WithdrawKey = 4'b0100;
    localparam atmPkg::atmButtons CancelKey   = 4'b1000;

    logic              clk;
    logic              arstN;
    atmPkg::switchWord switches;
    atmPkg::atmButtons buttons;
    atmPkg::segPattern seg;
    logic [7:0]        digitEn;

    atmPkg::segPattern recordedSeg [atmPkg::ScanDigits];
    int errorCount;
    int testStartErrors;
    int testsRun;
    int failedTests;
    int cycleCount;
    int balanceModel;   // expected balance

    atmTop #(
        .scanDivide (ScanDiv)
    ) u_dut (
        .clk      (clk),
        .arstN    (arstN),
        .switches (switches),
        .buttons  (buttons),
        .seg      (seg),
        .digitEn  (digitEn)
    );

    `include "atmTbChecks.svh"

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CycleLimit)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic atmPkg::displayFrame numberFrame(input int value);
        atmPkg::displayFrame f;
        f.slot5 = atmPkg::Blank;
        f.slot4 = atmPkg::Blank;
        f.slot3 = atmPkg::glyph'(4'((value / 1000) % 10));
        f.slot2 = atmPkg::glyph'(4'((value / 100) % 10));
        f.slot1 = atmPkg::glyph'(4'((value / 10) % 10));
        f.slot0 = atmPkg::glyph'(4'(value % 10));
        return f;
    endfunction

    function automatic atmPkg::displayFrame errorFrame(input int code);
        return '{atmPkg::LetterE, atmPkg::LetterR, atmPkg::LetterR,
                 atmPkg::LetterO, atmPkg::LetterR, atmPkg::glyph'(4'(code))};
    endfunction

    function automatic atmPkg::displayFrame idleFrame();
        return '{atmPkg::Blank, atmPkg::Blank, atmPkg::Dash,
                 atmPkg::Dash, atmPkg::Dash, atmPkg::Dash};
    endfunction

    task automatic setSwitches(input int value);
        @(posedge clk);
        #1;
        switches = atmPkg::switchWord'(value);
    endtask

    task automatic pressButton(input atmPkg::atmButtons strobe);
        @(posedge clk);
        #1;
        buttons = strobe;
        @(posedge clk);
        #1;
        buttons = '0;   // one-cycle strobe
    endtask

    task automatic expectFrame(input atmPkg::displayFrame expected);
        repeat (2 * FrameCycles) @(posedge clk);   // let the converter settle
        readFrame();
        checkFrame(expected);
    endtask

    task automatic login();
        setSwitches(atmPkg::Pin);
        pressButton(ConfirmKey);
        setSwitches(0);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errorCount != testStartErrors)
        begin
            failedTests++;
            $display("test %0d %s: %0d errors", testsRun, name, errorCount - testStartErrors);
        end
        else
        begin
            $display("test %0d %s: ok", testsRun, name);
        end
        testStartErrors = errorCount;
    endtask

    task automatic resetTest();
        expectFrame(idleFrame());
        login();
        expectFrame(numberFrame(balanceModel));
        finishTest("reset and login");
    endtask

    task automatic wrongPinTest();
        pressButton(CancelKey);
        balanceModel = atmPkg::InitialBalance;
        setSwitches(atmPkg::Pin + 1);
        pressButton(ConfirmKey);
        expectFrame(errorFrame(1));
        setSwitches(0);
        pressButton(ConfirmKey);
        expectFrame(idleFrame());
        finishTest("wrong pin");
    endtask

    task automatic withdrawTest();
        int amount;
        login();
        pressButton(WithdrawKey);
        setSwitches(123);
        expectFrame(numberFrame(123));
        amount = $urandom % (balanceModel + 1);
        setSwitches(amount);
        expectFrame(numberFrame(amount));   // typed amount follows switches
        pressButton(ConfirmKey);
        balanceModel = balanceModel - amount;
        expectFrame(numberFrame(balanceModel));
        setSwitches(0);
        pressButton(ConfirmKey);
        expectFrame(numberFrame(balanceModel));
        pressButton(WithdrawKey);
        amount = balanceModel + 1 + $urandom % (atmPkg::MaxBalance - balanceModel);
        setSwitches(amount);
        pressButton(ConfirmKey);
        expectFrame(errorFrame(2));
        setSwitches(0);
        pressButton(ConfirmKey);
        expectFrame(numberFrame(balanceModel));
        finishTest("withdraw");
    endtask

    task automatic depositTest();
        int amount;
        pressButton(DepositKey);
        amount = 1 + $urandom % (atmPkg::MaxBalance - balanceModel);
        setSwitches(amount);
        pressButton(ConfirmKey);
        balanceModel = balanceModel + amount;
        expectFrame(numberFrame(balanceModel));
        setSwitches(0);
        pressButton(ConfirmKey);
        pressButton(DepositKey);
        amount = atmPkg::MaxBalance + 1 - balanceModel + $urandom % balanceModel;
        setSwitches(amount);
        pressButton(ConfirmKey);
        expectFrame(errorFrame(3));
        setSwitches(0);
        pressButton(ConfirmKey);
        expectFrame(numberFrame(balanceModel));
        finishTest("deposit");
    endtask

    task automatic cancelTest();
        if (balanceModel == atmPkg::InitialBalance)
        begin
            pressButton(WithdrawKey);   // make sure the balance moved
            setSwitches(1);
            pressButton(ConfirmKey);
            balanceModel = balanceModel - 1;
            setSwitches(0);
            pressButton(ConfirmKey);
        end
        expectFrame(numberFrame(balanceModel));
        pressButton(CancelKey);
        balanceModel = atmPkg::InitialBalance;
        expectFrame(idleFrame());
        login();
        expectFrame(numberFrame(balanceModel));
        finishTest("cancel");
    endtask

    initial
    begin
        clk             = 1'b0;
        arstN           = 1'b0;
        switches        = '0;
        buttons         = '0;
        errorCount      = 0;
        testStartErrors = 0;
        testsRun        = 0;
        failedTests     = 0;
        cycleCount      = 0;
        balanceModel    = atmPkg::InitialBalance;
        void'($urandom(32'hea38));
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        resetTest();
        wrongPinTest();
        withdrawTest();
        depositTest();
        cancelTest();
        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, failedTests, errorCount);
        if (errorCount == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== atm.f ====
+incdir+.
atmPkg.sv
atmController.sv
binToBcd.sv
displayScan.sv
atmTop.sv
atmTb.sv
